// File: design/aib_red_pkg.sv
// **************************************************
// aib redundancy package: lane and pad counts,
// field widths and the repair command opcodes
// **************************************************
package aib_red_pkg;

  // logical lanes, lane 0 is the word strobe
  localparam int NUM_LANES = 8;

  // one spare pad above the top lane
  localparam int NUM_PADS = NUM_LANES + 1;

  // data rides on lanes 1 to NUM_LANES-1
  localparam int DATA_W = NUM_LANES - 1;

  // pad index, wide enough for the spare
  localparam int PAD_IDX_W = 4;

  // one drive strength code, n or p side
  localparam int DRV_W = 2;

  // repair command opcodes
  typedef enum logic [1:0] {
    // no effect
    CMD_NOP         = 2'd0,
    // record faulty pad from cmd_idx, repair on
    CMD_SET_FAULT   = 2'd1,
    // repair off, direct mapping
    CMD_CLEAR_FAULT = 2'd2,
    // load n and p drive codes of lane cmd_idx
    CMD_SET_DRIVE   = 2'd3
  } cmd_op_e;

endpackage

// File: design/pad_redundancy_mux.sv
// **************************************************
// pad redundancy mux: two-way select per pad on the
// transmit fields and per lane on the receive bit
// **************************************************
`timescale 1ns/100ps

module pad_redundancy_mux (
  // high selects the in1 side of every field
  input  logic                              shift_en,

  // transmit side, in0 own lane, in1 lane below
  input  logic                              lane_tx_in0,
  input  logic                              lane_tx_in1,
  input  logic                              lane_en_in0,
  input  logic                              lane_en_in1,
  input  logic [aib_red_pkg::DRV_W-1:0]     ndrv_in0,
  input  logic [aib_red_pkg::DRV_W-1:0]     ndrv_in1,
  input  logic [aib_red_pkg::DRV_W-1:0]     pdrv_in0,
  input  logic [aib_red_pkg::DRV_W-1:0]     pdrv_in1,

  // receive side, in0 own pad, in1 pad above
  input  logic                              pad_rx_in0,
  input  logic                              pad_rx_in1,

  // muxed pad fields
  output logic                              pad_tx,
  output logic                              pad_en,
  output logic [aib_red_pkg::DRV_W-1:0]     pad_ndrv,
  output logic [aib_red_pkg::DRV_W-1:0]     pad_pdrv,

  // muxed lane receive bit
  output logic                              lane_rx
);

  // transmit data and enable
  assign pad_tx   = shift_en ? lane_tx_in1 : lane_tx_in0;
  assign pad_en   = shift_en ? lane_en_in1 : lane_en_in0;

  // drive strengths follow the same lane as the data
  assign pad_ndrv = shift_en ? ndrv_in1 : ndrv_in0;
  assign pad_pdrv = shift_en ? pdrv_in1 : pdrv_in0;

  // receive select
  // shifted lanes read one pad up
  assign lane_rx  = shift_en ? pad_rx_in1 : pad_rx_in0;

endmodule

// File: design/repair_cmd_decode.sv
// **************************************************
// repair command decode: command/word arbitration,
// fault register, drive table and shift vector
// **************************************************
`timescale 1ns/100ps

module repair_cmd_decode (
  input  logic                                                  clk,
  input  logic                                                  rst,

  // command port
  input  logic                                                  cmd_valid,
  input  aib_red_pkg::cmd_op_e                                  cmd_op,
  input  logic [aib_red_pkg::PAD_IDX_W-1:0]                     cmd_idx,
  input  logic [aib_red_pkg::DRV_W-1:0]                         cmd_drv_n,
  input  logic [aib_red_pkg::DRV_W-1:0]                         cmd_drv_p,
  output logic                                                  cmd_ready,

  // transmit handshake
  input  logic                                                  tx_valid,
  output logic                                                  tx_ready,

  // launch register occupancy
  input  logic                                                  launch_busy,

  // configuration to the pad array
  output logic [aib_red_pkg::NUM_PADS-1:0]                      shift_en,
  output logic [aib_red_pkg::NUM_PADS-1:0]                      pad_fault,
  output logic [aib_red_pkg::NUM_LANES*aib_red_pkg::DRV_W-1:0]  drv_n_tbl,
  output logic [aib_red_pkg::NUM_LANES*aib_red_pkg::DRV_W-1:0]  drv_p_tbl
);

  logic                                  cmd_fire;
  logic                                  idx_is_pad;
  logic                                  repair_en;
  logic [aib_red_pkg::PAD_IDX_W-1:0]     fault_idx;

  // mapping only changes while no word is on the pads
  assign cmd_ready  = ~launch_busy;
  assign cmd_fire   = cmd_valid & cmd_ready;

  // a pending command holds off new words
  // so the launch register drains and the command wins
  assign tx_ready   = ~cmd_valid;

  assign idx_is_pad = int'(cmd_idx) < aib_red_pkg::NUM_PADS;

  // fault register and drive table
  always_ff @(posedge clk) begin
    if (rst) begin
      repair_en <= 1'b0;
      fault_idx <= '0;
      drv_n_tbl <= '0;
      drv_p_tbl <= '0;
    end else if (cmd_fire) begin
      case (cmd_op)
        aib_red_pkg::CMD_SET_FAULT: begin
          // bad index drops the command
          if (idx_is_pad) begin
            repair_en <= 1'b1;
            fault_idx <= cmd_idx;
          end
        end
        aib_red_pkg::CMD_CLEAR_FAULT: begin
          repair_en <= 1'b0;
        end
        aib_red_pkg::CMD_SET_DRIVE: begin
          // only lanes 0 to NUM_LANES-1 match
          for (int l = 0; l < aib_red_pkg::NUM_LANES; l++) begin
            if (int'(cmd_idx) == l) begin
              drv_n_tbl[l*aib_red_pkg::DRV_W +: aib_red_pkg::DRV_W] <= cmd_drv_n;
              drv_p_tbl[l*aib_red_pkg::DRV_W +: aib_red_pkg::DRV_W] <= cmd_drv_p;
            end
          end
        end
        default: begin
          // nop
        end
      endcase
    end
  end

  // thermometer shift above the fault
  // plus one-hot mask at the fault itself
  always_comb begin
    for (int p = 0; p < aib_red_pkg::NUM_PADS; p++) begin
      shift_en[p]  = repair_en && (p > int'(fault_idx));
      pad_fault[p] = repair_en && (p == int'(fault_idx));
    end
  end

  // stored fault index must name a real pad
  fault_idx_range_a: assert property (@(posedge clk) disable iff (rst)
    repair_en |-> (int'(fault_idx) < aib_red_pkg::NUM_PADS))
    else $error("FAIL fault_idx out of range: fault_idx=%h", fault_idx);

  // never a command and a word on the same edge
  // launch register stays empty after a command edge
  one_grant_a: assert property (@(posedge clk) disable iff (rst)
    (cmd_fire && tx_valid) |=> !launch_busy)
    else $error("FAIL word launched with a command: launch_busy=%h", launch_busy);

endmodule

// File: design/pad_array_remap.sv
// **************************************************
// pad array remap: launch register and per-pad
// redundancy muxes mapping lanes onto pads
// **************************************************
`timescale 1ns/100ps

module pad_array_remap (
  input  logic                                                  clk,
  input  logic                                                  rst,

  // accepted transmit word
  input  logic                                                  tx_fire,
  input  logic [aib_red_pkg::DATA_W-1:0]                        tx_data,

  // configuration from the decoder
  input  logic [aib_red_pkg::NUM_PADS-1:0]                      shift_en,
  input  logic [aib_red_pkg::NUM_PADS-1:0]                      pad_fault,
  input  logic [aib_red_pkg::NUM_LANES*aib_red_pkg::DRV_W-1:0]  drv_n_tbl,
  input  logic [aib_red_pkg::NUM_LANES*aib_red_pkg::DRV_W-1:0]  drv_p_tbl,

  output logic                                                  launch_busy,

  // pads
  output logic [aib_red_pkg::NUM_PADS-1:0]                      pad_tx,
  output logic [aib_red_pkg::NUM_PADS-1:0]                      pad_txen,
  output logic [aib_red_pkg::NUM_PADS*aib_red_pkg::DRV_W-1:0]   pad_ndrv,
  output logic [aib_red_pkg::NUM_PADS*aib_red_pkg::DRV_W-1:0]   pad_pdrv,
  input  logic [aib_red_pkg::NUM_PADS-1:0]                      pad_rx,

  // remapped receive lanes
  output logic [aib_red_pkg::NUM_LANES-1:0]                     lane_rx
);

  localparam int EXT_W = aib_red_pkg::NUM_LANES + 2;
  localparam int DW    = aib_red_pkg::DRV_W;

  logic [aib_red_pkg::DATA_W-1:0]     launch_data;
  logic [aib_red_pkg::NUM_LANES-1:0]  lane_tx;

  // lanes padded with an empty lane at each end
  // index j carries lane j-1
  logic [EXT_W-1:0]                   tx_ext;
  logic [EXT_W-1:0]                   en_ext;
  logic [EXT_W*DW-1:0]                ndrv_ext;
  logic [EXT_W*DW-1:0]                pdrv_ext;

  // pads with an empty pad below, index j is pad j-1
  logic [aib_red_pkg::NUM_PADS:0]     rx_ext;

  logic [aib_red_pkg::NUM_PADS-1:0]   mux_en;
  logic [aib_red_pkg::NUM_PADS-1:0]   rx_mux;

  // launch register, strobe lives one cycle per word
  always_ff @(posedge clk) begin
    if (rst) begin
      launch_busy <= 1'b0;
    end else begin
      launch_busy <= tx_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (tx_fire) begin
      launch_data <= tx_data;
    end
  end

  // strobe on lane 0, data above it
  assign lane_tx  = {launch_data, launch_busy};

  assign tx_ext   = {1'b0, lane_tx, 1'b0};
  assign en_ext   = {1'b0, {aib_red_pkg::NUM_LANES{1'b1}}, 1'b0};
  assign ndrv_ext = {{DW{1'b0}}, drv_n_tbl, {DW{1'b0}}};
  assign pdrv_ext = {{DW{1'b0}}, drv_p_tbl, {DW{1'b0}}};
  assign rx_ext   = {pad_rx, 1'b0};

  // pad p picks lane p or lane p-1
  // mux p also serves receive of lane p-1 from pad p-1 or pad p
  for (genvar p = 0; p < aib_red_pkg::NUM_PADS; p++) begin : g_pad
    pad_redundancy_mux pad_redundancy_mux_inst (
      .shift_en    (shift_en[p]),
      .lane_tx_in0 (tx_ext[p+1]),
      .lane_tx_in1 (tx_ext[p]),
      .lane_en_in0 (en_ext[p+1]),
      .lane_en_in1 (en_ext[p]),
      .ndrv_in0    (ndrv_ext[(p+1)*DW +: DW]),
      .ndrv_in1    (ndrv_ext[p*DW +: DW]),
      .pdrv_in0    (pdrv_ext[(p+1)*DW +: DW]),
      .pdrv_in1    (pdrv_ext[p*DW +: DW]),
      .pad_rx_in0  (rx_ext[p]),
      .pad_rx_in1  (rx_ext[p+1]),
      .pad_tx      (pad_tx[p]),
      .pad_en      (mux_en[p]),
      .pad_ndrv    (pad_ndrv[p*DW +: DW]),
      .pad_pdrv    (pad_pdrv[p*DW +: DW]),
      .lane_rx     (rx_mux[p])
    );
  end

  // faulty pad stays off
  assign pad_txen = mux_en & ~pad_fault;

  // mux 0 has no lane below it on receive
  assign lane_rx  = rx_mux[aib_red_pkg::NUM_PADS-1:1];

  // shifted pads form one block at the top, pad 0 never shifts
  shift_thermo_a: assert property (@(posedge clk) disable iff (rst)
    ((shift_en[aib_red_pkg::NUM_PADS-2:0] & ~shift_en[aib_red_pkg::NUM_PADS-1:1]) == '0)
    && !shift_en[0])
    else $error("FAIL shift_en not thermometer: shift_en=%h", shift_en);

endmodule

// File: design/rx_capture.sv
// **************************************************
// rx capture: registers remapped lanes into the
// receive strobe and data word
// **************************************************
`timescale 1ns/100ps

module rx_capture (
  input  logic                               clk,
  input  logic                               rst,

  // lanes after the receive muxes
  input  logic [aib_red_pkg::NUM_LANES-1:0]  lane_rx,

  // received word, no back-pressure
  output logic                               rx_valid,
  output logic [aib_red_pkg::DATA_W-1:0]     rx_data
);

  logic                              strobe;
  logic [aib_red_pkg::DATA_W-1:0]    lane_data;

  // lane 0 strobe, lanes 1 up data
  assign strobe    = lane_rx[0];
  assign lane_data = lane_rx[aib_red_pkg::NUM_LANES-1:1];

  // one valid pulse per strobe cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= strobe;
    end
  end

  // hold last word between strobes
  always_ff @(posedge clk) begin
    if (strobe) begin
      rx_data <= lane_data;
    end
  end

  // strobe path must resolve through the pad loop
  rx_valid_known_a: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(rx_valid))
    else $error("FAIL rx_valid unknown: rx_valid=%h", rx_valid);

endmodule

// File: design/aib_redundancy_top.sv
// **************************************************
// aib redundancy top: repaired parallel pad channel,
// command decode, lane remap and receive capture
// **************************************************
`timescale 1ns/100ps

module aib_redundancy_top (
  input  logic                                                 clk,
  input  logic                                                 rst,

  // command port
  input  logic                                                 cmd_valid,
  output logic                                                 cmd_ready,
  input  aib_red_pkg::cmd_op_e                                 cmd_op,
  input  logic [aib_red_pkg::PAD_IDX_W-1:0]                    cmd_idx,
  input  logic [aib_red_pkg::DRV_W-1:0]                        cmd_drv_n,
  input  logic [aib_red_pkg::DRV_W-1:0]                        cmd_drv_p,

  // transmit port
  input  logic                                                 tx_valid,
  output logic                                                 tx_ready,
  input  logic [aib_red_pkg::DATA_W-1:0]                       tx_data,

  // receive port
  output logic                                                 rx_valid,
  output logic [aib_red_pkg::DATA_W-1:0]                       rx_data,

  // pads
  output logic [aib_red_pkg::NUM_PADS-1:0]                     pad_tx,
  output logic [aib_red_pkg::NUM_PADS-1:0]                     pad_txen,
  output logic [aib_red_pkg::NUM_PADS*aib_red_pkg::DRV_W-1:0]  pad_ndrv,
  output logic [aib_red_pkg::NUM_PADS*aib_red_pkg::DRV_W-1:0]  pad_pdrv,
  input  logic [aib_red_pkg::NUM_PADS-1:0]                     pad_rx
);

  logic                                                  tx_fire;
  logic                                                  launch_busy;
  logic [aib_red_pkg::NUM_PADS-1:0]                      shift_en;
  logic [aib_red_pkg::NUM_PADS-1:0]                      pad_fault;
  logic [aib_red_pkg::NUM_LANES*aib_red_pkg::DRV_W-1:0]  drv_n_tbl;
  logic [aib_red_pkg::NUM_LANES*aib_red_pkg::DRV_W-1:0]  drv_p_tbl;
  logic [aib_red_pkg::NUM_LANES-1:0]                     lane_rx;

  // word handshake
  assign tx_fire = tx_valid & tx_ready;

  repair_cmd_decode repair_cmd_decode_inst (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid   (cmd_valid),
    .cmd_op      (cmd_op),
    .cmd_idx     (cmd_idx),
    .cmd_drv_n   (cmd_drv_n),
    .cmd_drv_p   (cmd_drv_p),
    .cmd_ready   (cmd_ready),
    .tx_valid    (tx_valid),
    .tx_ready    (tx_ready),
    .launch_busy (launch_busy),
    .shift_en    (shift_en),
    .pad_fault   (pad_fault),
    .drv_n_tbl   (drv_n_tbl),
    .drv_p_tbl   (drv_p_tbl)
  );

  pad_array_remap pad_array_remap_inst (
    .clk         (clk),
    .rst         (rst),
    .tx_fire     (tx_fire),
    .tx_data     (tx_data),
    .shift_en    (shift_en),
    .pad_fault   (pad_fault),
    .drv_n_tbl   (drv_n_tbl),
    .drv_p_tbl   (drv_p_tbl),
    .launch_busy (launch_busy),
    .pad_tx      (pad_tx),
    .pad_txen    (pad_txen),
    .pad_ndrv    (pad_ndrv),
    .pad_pdrv    (pad_pdrv),
    .pad_rx      (pad_rx),
    .lane_rx     (lane_rx)
  );

  rx_capture rx_capture_inst (
    .clk      (clk),
    .rst      (rst),
    .lane_rx  (lane_rx),
    .rx_valid (rx_valid),
    .rx_data  (rx_data)
  );

endmodule

// File: tests/tb_clock_gen.sv
// **************************************************
// testbench clock and reset generator
// **************************************************
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  localparam int HALF_PERIOD = 2;
  localparam int RESET_CYCLES = 10;

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // reset held high for the first cycles
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: tests/aib_redundancy_tb.sv
// **************************************************
// testbench for the repaired pad channel with
// pad loopback, stuck pad and lane remap checks
// **************************************************
`timescale 1ns/100ps

module aib_redundancy_tb;

  localparam logic [31:0] SEED = 32'h0c5e_f61b;
  // planned stimulus length in cycles
  localparam int STIM_CYCLES = 450;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 200;
  // no pad held at 0
  localparam logic [3:0] NO_STUCK = 4'hf;
  localparam int NP = aib_red_pkg::NUM_PADS;
  localparam int DW = aib_red_pkg::DRV_W;

  logic clk;
  logic rst;
  logic cmd_valid;
  logic cmd_ready;
  aib_red_pkg::cmd_op_e cmd_op;
  logic [aib_red_pkg::PAD_IDX_W-1:0] cmd_idx;
  logic [DW-1:0] cmd_drv_n;
  logic [DW-1:0] cmd_drv_p;
  logic tx_valid;
  logic tx_ready;
  logic [aib_red_pkg::DATA_W-1:0] tx_data;
  logic rx_valid;
  logic [aib_red_pkg::DATA_W-1:0] rx_data;
  logic [NP-1:0] pad_tx;
  logic [NP-1:0] pad_txen;
  logic [NP-1:0] pad_rx;
  logic [NP*DW-1:0] pad_ndrv;
  logic [NP*DW-1:0] pad_pdrv;
  logic [3:0] stuck_pad;
  logic [31:0] lfsr;

  // reference model state
  logic m_repair;
  logic [3:0] m_fault;
  logic [aib_red_pkg::NUM_LANES*DW-1:0] m_drv_n;
  logic [aib_red_pkg::NUM_LANES*DW-1:0] m_drv_p;
  // acc1 word in launch register, acc2 word due on rx
  logic acc1;
  logic acc2;
  logic [aib_red_pkg::DATA_W-1:0] launch_word;
  logic [aib_red_pkg::DATA_W-1:0] exp1;
  logic [aib_red_pkg::DATA_W-1:0] exp2;
  int errors = 0;
  int words_checked = 0;
  int cycles = 0;

  tb_clock_gen tb_clock_gen_inst (.clk(clk), .rst(rst));

  aib_redundancy_top aib_redundancy_top_inst (
    .clk(clk), .rst(rst),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_op(cmd_op), .cmd_idx(cmd_idx),
    .cmd_drv_n(cmd_drv_n), .cmd_drv_p(cmd_drv_p),
    .tx_valid(tx_valid), .tx_ready(tx_ready), .tx_data(tx_data),
    .rx_valid(rx_valid), .rx_data(rx_data),
    .pad_tx(pad_tx), .pad_txen(pad_txen), .pad_ndrv(pad_ndrv), .pad_pdrv(pad_pdrv),
    .pad_rx(pad_rx)
  );

  // loopback, disabled or stuck pads read 0
  always_comb begin
    for (int p = 0; p < NP; p++) begin
      pad_rx[p] = pad_tx[p] & pad_txen[p] & (p != int'(stuck_pad));
    end
  end

  // galois lfsr, one step per bit
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic get_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // lane driven onto pad p, -1 for none
  // pads above the fault take the lane below
  function automatic int pad_source(int p, logic rep, logic [3:0] flt);
    int src;
    src = (rep && p > int'(flt)) ? p - 1 : p;
    if (src >= aib_red_pkg::NUM_LANES) begin
      src = -1;
    end
    return src;
  endfunction

  // pad that lane l is read from
  function automatic int lane_pad(int l, logic rep, logic [3:0] flt);
    return (rep && l >= int'(flt)) ? l + 1 : l;
  endfunction

  function automatic logic [NP-1:0] expected_txen(logic rep, logic [3:0] flt);
    logic [NP-1:0] en;
    for (int p = 0; p < NP; p++) begin
      en[p] = (pad_source(p, rep, flt) >= 0) && !(rep && p == int'(flt));
    end
    return en;
  endfunction

  function automatic logic [NP*DW-1:0] expected_drive(
    logic [aib_red_pkg::NUM_LANES*DW-1:0] tbl, logic rep, logic [3:0] flt);
    logic [NP*DW-1:0] img;
    int src;
    img = '0;
    for (int p = 0; p < NP; p++) begin
      src = pad_source(p, rep, flt);
      if (src >= 0) begin
        img[p*DW +: DW] = tbl[src*DW +: DW];
      end
    end
    return img;
  endfunction

  function automatic logic [NP-1:0] expected_pad_tx(
    logic [aib_red_pkg::NUM_LANES-1:0] lanes, logic rep, logic [3:0] flt);
    logic [NP-1:0] img;
    int src;
    img = '0;
    for (int p = 0; p < NP; p++) begin
      src = pad_source(p, rep, flt);
      if (src >= 0) begin
        img[p] = lanes[src];
      end
    end
    return img & expected_txen(rep, flt);
  endfunction

  // word seen after the loop, stuck pad clears its lane
  function automatic logic [aib_red_pkg::DATA_W-1:0] looped_word(
    logic [aib_red_pkg::DATA_W-1:0] d, logic rep, logic [3:0] flt, logic [3:0] stk);
    logic [aib_red_pkg::DATA_W-1:0] w;
    w = d;
    for (int l = 1; l < aib_red_pkg::NUM_LANES; l++) begin
      if (lane_pad(l, rep, flt) == int'(stk)) begin
        w[l-1] = 1'b0;
      end
    end
    return w;
  endfunction

  // model follows accepted commands and words
  always @(posedge clk) begin
    if (rst) begin
      m_repair <= 1'b0;
      m_fault <= '0;
      m_drv_n <= '0;
      m_drv_p <= '0;
      acc1 <= 1'b0;
      acc2 <= 1'b0;
    end else begin
      if (cmd_valid && cmd_ready) begin
        case (cmd_op)
          aib_red_pkg::CMD_SET_FAULT: begin
            if (int'(cmd_idx) < NP) begin
              m_repair <= 1'b1;
              m_fault <= cmd_idx;
            end
          end
          aib_red_pkg::CMD_CLEAR_FAULT: m_repair <= 1'b0;
          aib_red_pkg::CMD_SET_DRIVE: begin
            if (int'(cmd_idx) < aib_red_pkg::NUM_LANES) begin
              m_drv_n[int'(cmd_idx)*DW +: DW] <= cmd_drv_n;
              m_drv_p[int'(cmd_idx)*DW +: DW] <= cmd_drv_p;
            end
          end
          default: begin
          end
        endcase
      end
      acc1 <= tx_valid && tx_ready;
      acc2 <= acc1;
      if (tx_valid && tx_ready) begin
        launch_word <= tx_data;
        exp1 <= looped_word(tx_data, m_repair, m_fault, stuck_pad);
      end
      exp2 <= exp1;
      if (rx_valid) begin
        words_checked <= words_checked + 1;
      end
    end
  end

  // one rx pulse per word, one cycle after acceptance
  rx_valid_timing_a: assert property (@(posedge clk) disable iff (rst) rx_valid == acc2)
    else begin
      errors++;
      $display("FAIL rx_valid got %h expected %h", $sampled(rx_valid), $sampled(acc2));
    end

  rx_data_a: assert property (@(posedge clk) disable iff (rst) rx_valid |-> rx_data == exp2)
    else begin
      errors++;
      $display("FAIL rx_data got %h expected %h", $sampled(rx_data), $sampled(exp2));
    end

  // command port closed while a word is launched
  cmd_ready_a: assert property (@(posedge clk) disable iff (rst) cmd_ready == !acc1)
    else begin
      errors++;
      $display("FAIL cmd_ready got %h expected %h", $sampled(cmd_ready), !$sampled(acc1));
    end

  tx_ready_a: assert property (@(posedge clk) disable iff (rst)
    (cmd_valid && cmd_ready) |-> !tx_ready)
    else begin
      errors++;
      $display("FAIL tx_ready got %h expected %h", $sampled(tx_ready), 1'b0);
    end

  reset_state_a: assert property (@(posedge clk)
    $fell(rst) |-> (cmd_ready && tx_ready && !rx_valid))
    else begin
      errors++;
      $display("FAIL reset cmd_ready %h tx_ready %h rx_valid %h expected 1 1 0",
        $sampled(cmd_ready), $sampled(tx_ready), $sampled(rx_valid));
    end

  pad_txen_a: assert property (@(posedge clk) disable iff (rst)
    pad_txen == expected_txen(m_repair, m_fault))
    else begin
      errors++;
      $display("FAIL pad_txen got %h expected %h", $sampled(pad_txen),
        expected_txen($sampled(m_repair), $sampled(m_fault)));
    end

  pad_ndrv_a: assert property (@(posedge clk) disable iff (rst)
    pad_ndrv == expected_drive(m_drv_n, m_repair, m_fault))
    else begin
      errors++;
      $display("FAIL pad_ndrv got %h expected %h", $sampled(pad_ndrv),
        expected_drive($sampled(m_drv_n), $sampled(m_repair), $sampled(m_fault)));
    end

  pad_pdrv_a: assert property (@(posedge clk) disable iff (rst)
    pad_pdrv == expected_drive(m_drv_p, m_repair, m_fault))
    else begin
      errors++;
      $display("FAIL pad_pdrv got %h expected %h", $sampled(pad_pdrv),
        expected_drive($sampled(m_drv_p), $sampled(m_repair), $sampled(m_fault)));
    end

  // strobe and data lanes on the mapped pads
  pad_tx_a: assert property (@(posedge clk) disable iff (rst)
    acc1 |-> (pad_tx & pad_txen) == expected_pad_tx({launch_word, 1'b1}, m_repair, m_fault))
    else begin
      errors++;
      $display("FAIL pad_tx got %h expected %h", $sampled(pad_tx & pad_txen),
        expected_pad_tx({$sampled(launch_word), 1'b1}, $sampled(m_repair), $sampled(m_fault)));
    end

  task automatic finish_run(input logic timed_out);
    $display("errors %0d, words checked %0d, cycles %0d", errors, words_checked, cycles);
    if (errors == 0 && !timed_out) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, stimulus did not complete", cycles);
      finish_run(1'b1);
    end
  end

  task automatic send_cmd(input aib_red_pkg::cmd_op_e op, input logic [3:0] idx,
                          input logic [DW-1:0] dn, input logic [DW-1:0] dp);
    cmd_valid <= 1'b1;
    cmd_op <= op;
    cmd_idx <= idx;
    cmd_drv_n <= dn;
    cmd_drv_p <= dp;
    @(posedge clk);
    while (!cmd_ready) begin
      @(posedge clk);
    end
    cmd_valid <= 1'b0;
    cmd_op <= aib_red_pkg::CMD_NOP;
  endtask

  task automatic send_burst(input int n);
    logic [31:0] v;
    for (int i = 0; i < n; i++) begin
      get_bits(aib_red_pkg::DATA_W, v);
      tx_valid <= 1'b1;
      tx_data <= v[aib_red_pkg::DATA_W-1:0];
      @(posedge clk);
      while (!tx_ready) begin
        @(posedge clk);
      end
      tx_valid <= 1'b0;
      // random idle cycle between words
      get_bits(1, v);
      if (v[0]) begin
        @(posedge clk);
      end
    end
  endtask

  // wait until no word is left in flight
  task automatic drain();
    @(posedge clk);
    while (acc1 || acc2) begin
      @(posedge clk);
    end
  endtask

  initial begin
    logic [31:0] v;
    logic [3:0] s;
    lfsr = SEED;
    cmd_valid = 1'b0;
    cmd_op = aib_red_pkg::CMD_NOP;
    cmd_idx = '0;
    cmd_drv_n = '0;
    cmd_drv_p = '0;
    tx_valid = 1'b0;
    tx_data = '0;
    stuck_pad = NO_STUCK;
    @(posedge clk);
    while (rst) begin
      @(posedge clk);
    end

    // direct mapping and clean loop
    send_burst(64);
    send_cmd(aib_red_pkg::CMD_SET_DRIVE, 4'd2, 2'd3, 2'd1);
    send_cmd(aib_red_pkg::CMD_SET_DRIVE, 4'd7, 2'd1, 2'd2);
    drain();

    // stuck data pad with repair off
    get_bits(3, v);
    stuck_pad <= 4'(v % 7 + 1);
    send_burst(16);
    drain();

    // repair around a random pad then back to direct mapping
    for (int r = 0; r < 4; r++) begin
      get_bits(3, v);
      s = 4'(v + 1);
      stuck_pad <= s;
      send_cmd(aib_red_pkg::CMD_SET_FAULT, s, 2'd0, 2'd0);
      for (int k = 0; k < 2; k++) begin
        get_bits(7, v);
        send_cmd(aib_red_pkg::CMD_SET_DRIVE, {1'b0, v[2:0]}, v[4:3], v[6:5]);
      end
      // out of range index is dropped
      send_cmd(aib_red_pkg::CMD_SET_FAULT, 4'hc, 2'd0, 2'd0);
      send_cmd(aib_red_pkg::CMD_NOP, 4'd0, 2'd3, 2'd3);
      send_burst(16);
      send_cmd(aib_red_pkg::CMD_CLEAR_FAULT, 4'd0, 2'd0, 2'd0);
      send_burst(16);
      drain();
    end

    finish_run(1'b0);
  end

endmodule

// File: project.f
design/aib_red_pkg.sv
design/pad_redundancy_mux.sv
design/repair_cmd_decode.sv
design/pad_array_remap.sv
design/rx_capture.sv
design/aib_redundancy_top.sv
tests/tb_clock_gen.sv
tests/aib_redundancy_tb.sv

// File: Makefile
# Verilator build and run of the pad redundancy testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

obj_dir/Vaib_redundancy_tb: project.f $(wildcard design/*.sv tests/*.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module aib_redundancy_tb -f project.f -o Vaib_redundancy_tb

test: obj_dir/Vaib_redundancy_tb
	./obj_dir/Vaib_redundancy_tb | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
